// File: common/rv64_pkg.sv
package rv64_pkg;

    // register width of the core
    localparam int XLEN = 64;

    // register values, pc and bus addresses
    typedef logic [XLEN-1:0] xlen_t;
    // instructions and bus data
    typedef logic [31:0]     word_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcodes, instruction bits 6:0
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // one value per supported instruction
    // I_NONE covers unknown words and bubbles, retires with no effect
    typedef enum logic [4:0] {
        I_LUI,
        I_AUIPC,
        I_ADDI,
        I_SLLI,
        I_SRLI,
        I_ADD,
        I_SUB,
        I_SLT,
        I_JAL,
        I_JALR,
        I_BEQ,
        I_LW,
        I_LWU,
        I_LD,
        I_SW,
        I_SD,
        I_MRET,
        I_NONE
    } inst_class_e;

    // interrupt flag in the top bit, cause 11 = machine external
    localparam xlen_t MCAUSE_EXT_IRQ = {1'b1, 59'd0, 4'd11};

    // mstatus bit positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // reset values
    // opcode 0000001 matches nothing, so the reset word decodes as I_NONE
    localparam word_t IR_RESET      = 32'h0000_0001;
    // interrupts enabled out of reset
    localparam xlen_t MSTATUS_RESET = xlen_t'(64'd1 << MSTATUS_MIE_BIT);

endpackage

// File: source/rv64_decoder.sv
`timescale 1ns/1ps

module rv64_decoder
    import rv64_pkg::*;
(
    input  word_t       ir_i,
    output inst_class_e inst_class_o,
    output reg_idx_t    rd_o,
    output reg_idx_t    rs1_o,
    output reg_idx_t    rs2_o,
    output xlen_t       imm_i_o,
    output xlen_t       imm_s_o,
    output xlen_t       imm_u_o,
    output xlen_t       imm_j_o,
    output xlen_t       imm_b_o,
    output logic [5:0]  shamt_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = ir_i[6:0];
    assign funct3 = ir_i[14:12];
    assign funct7 = ir_i[31:25];

    // register fields sit at fixed positions in every format
    assign rd_o  = ir_i[11:7];
    assign rs1_o = ir_i[19:15];
    assign rs2_o = ir_i[24:20];

    // immediates, all sign-extended from bit 31
    assign imm_i_o = {{52{ir_i[31]}}, ir_i[31:20]};
    assign imm_s_o = {{52{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_u_o = {{32{ir_i[31]}}, ir_i[31:12], 12'b0};
    // jal offset, 21 bits with implied zero lsb
    assign imm_j_o = {{44{ir_i[31]}}, ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
    // branch offset, 13 bits with implied zero lsb
    assign imm_b_o = {{52{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    // rv64 shift amount is 6 bits
    assign shamt_o = ir_i[25:20];

    always_comb begin
        inst_class_o = I_NONE;
        case (opcode)
            OPC_LUI:   inst_class_o = I_LUI;
            OPC_AUIPC: inst_class_o = I_AUIPC;
            OPC_JAL:   inst_class_o = I_JAL;
            OPC_OP_IMM: begin
                // shifts need the upper six bits clear
                if (funct3 == 3'b000) inst_class_o = I_ADDI;
                else if (funct3 == 3'b001 && ir_i[31:26] == 6'b0) inst_class_o = I_SLLI;
                else if (funct3 == 3'b101 && ir_i[31:26] == 6'b0) inst_class_o = I_SRLI;
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: inst_class_o = I_ADD;
                    10'b0100000_000: inst_class_o = I_SUB;
                    10'b0000000_010: inst_class_o = I_SLT;
                    default:         inst_class_o = I_NONE;
                endcase
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) inst_class_o = I_JALR;
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000) inst_class_o = I_BEQ;
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b010:  inst_class_o = I_LW;
                    3'b110:  inst_class_o = I_LWU;
                    3'b011:  inst_class_o = I_LD;
                    default: inst_class_o = I_NONE;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b010:  inst_class_o = I_SW;
                    3'b011:  inst_class_o = I_SD;
                    default: inst_class_o = I_NONE;
                endcase
            end
            OPC_SYSTEM: begin
                // mret is the full word 0x30200073
                if (ir_i[31:7] == {12'h302, 13'd0}) inst_class_o = I_MRET;
            end
            default: inst_class_o = I_NONE;
        endcase
    end

endmodule

// File: source/rv64_regfile.sv
`timescale 1ns/1ps

module rv64_regfile
    import rv64_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t rd_i,
    input  logic     rd_we_i,
    input  xlen_t    rd_data_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o
);

    xlen_t regs_q [32];

    // x0 is never written, so it reads as zero after reset
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (rd_we_i && rd_i != '0) begin
            regs_q[rd_i] <= rd_data_i;
        end
    end

    // combinational reads, old value during a write cycle
    assign rs1_data_o = regs_q[rs1_i];
    assign rs2_data_o = regs_q[rs2_i];

endmodule

// File: source/rv64_alu.sv
`timescale 1ns/1ps

module rv64_alu
    import rv64_pkg::*;
(
    input  inst_class_e inst_class_i,
    input  xlen_t       rs1_data_i,
    input  xlen_t       rs2_data_i,
    input  xlen_t       imm_i_i,
    input  xlen_t       imm_u_i,
    input  xlen_t       imm_j_i,
    input  xlen_t       imm_b_i,
    input  logic [5:0]  shamt_i,
    input  xlen_t       pc_i,
    output xlen_t       result_o,
    output logic        result_we_o,
    output logic        redirect_o,
    output xlen_t       target_o
);

    xlen_t link;
    xlen_t jalr_sum;

    // return address of jal and jalr
    assign link     = pc_i + 64'd4;
    assign jalr_sum = rs1_data_i + imm_i_i;

    always_comb begin
        result_o    = '0;
        result_we_o = 1'b1;
        redirect_o  = 1'b0;
        target_o    = pc_i + imm_j_i;
        case (inst_class_i)
            I_LUI:   result_o = imm_u_i;
            I_AUIPC: result_o = pc_i + imm_u_i;
            I_ADDI:  result_o = rs1_data_i + imm_i_i;
            I_SLLI:  result_o = rs1_data_i << shamt_i;
            I_SRLI:  result_o = rs1_data_i >> shamt_i;
            I_ADD:   result_o = rs1_data_i + rs2_data_i;
            I_SUB:   result_o = rs1_data_i - rs2_data_i;
            I_SLT:   result_o = {{(XLEN-1){1'b0}}, $signed(rs1_data_i) < $signed(rs2_data_i)};
            I_JAL: begin
                result_o   = link;
                redirect_o = 1'b1;
            end
            I_JALR: begin
                // target lsb forced to zero
                result_o   = link;
                redirect_o = 1'b1;
                target_o   = {jalr_sum[XLEN-1:1], 1'b0};
            end
            I_BEQ: begin
                result_we_o = 1'b0;
                redirect_o  = (rs1_data_i == rs2_data_i);
                target_o    = pc_i + imm_b_i;
            end
            default: result_we_o = 1'b0;
        endcase
    end

endmodule

// File: mem_unit/rv64_mem_seq.sv
`timescale 1ns/1ps

module rv64_mem_seq
    import rv64_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  inst_class_e inst_class_i,
    input  logic        exec_i,
    input  xlen_t       rs1_data_i,
    input  xlen_t       rs2_data_i,
    input  xlen_t       imm_i_i,
    input  xlen_t       imm_s_i,
    input  word_t       bus_read_data_i,
    output xlen_t       bus_address_o,
    output word_t       bus_write_data_o,
    output logic        bus_write_enable_o,
    output logic        bus_read_enable_o,
    output logic        load_we_o,
    output xlen_t       load_data_o,
    output logic        mem_hold_o
);

    // step of the instruction currently in ir
    typedef enum logic [1:0] {
        MS_IDLE,
        MS_FIRST,
        MS_SECOND
    } mem_step_e;

    mem_step_e step_q;
    mem_step_e step_d;
    xlen_t     load_addr;
    xlen_t     store_addr;
    xlen_t     addr_d;
    word_t     wdata_d;
    word_t     low_word_q;
    logic      rd_en_d;
    logic      wr_en_d;
    logic      low_capture;

    assign load_addr  = rs1_data_i + imm_i_i;
    assign store_addr = rs1_data_i + imm_s_i;

    // re-present the instruction while another step follows
    // depends on ir and step only, not on exec
    always_comb begin
        case (inst_class_i)
            I_LW, I_LWU, I_SD: mem_hold_o = (step_q == MS_IDLE);
            I_LD:              mem_hold_o = (step_q != MS_SECOND);
            default:           mem_hold_o = 1'b0;
        endcase
    end

    always_comb begin
        step_d      = step_q;
        rd_en_d     = 1'b0;
        wr_en_d     = 1'b0;
        addr_d      = load_addr;
        wdata_d     = rs2_data_i[31:0];
        low_capture = 1'b0;
        load_we_o   = 1'b0;
        // lw default, sign-extended
        load_data_o = {{32{bus_read_data_i[31]}}, bus_read_data_i};
        if (exec_i) begin
            case (inst_class_i)
                I_LW, I_LWU: begin
                    if (step_q == MS_IDLE) begin
                        rd_en_d = 1'b1;
                        step_d  = MS_FIRST;
                    end else begin
                        // read data valid since the bubble
                        load_we_o = 1'b1;
                        step_d    = MS_IDLE;
                        if (inst_class_i == I_LWU) begin
                            load_data_o = {32'd0, bus_read_data_i};
                        end
                    end
                end
                I_LD: begin
                    case (step_q)
                        MS_IDLE: begin
                            rd_en_d = 1'b1;
                            step_d  = MS_FIRST;
                        end
                        MS_FIRST: begin
                            // keep low word, fetch high word
                            low_capture = 1'b1;
                            rd_en_d     = 1'b1;
                            addr_d      = load_addr + 64'd4;
                            step_d      = MS_SECOND;
                        end
                        default: begin
                            load_we_o   = 1'b1;
                            load_data_o = {bus_read_data_i, low_word_q};
                            step_d      = MS_IDLE;
                        end
                    endcase
                end
                I_SW: begin
                    wr_en_d = 1'b1;
                    addr_d  = store_addr;
                end
                I_SD: begin
                    wr_en_d = 1'b1;
                    if (step_q == MS_IDLE) begin
                        addr_d = store_addr;
                        step_d = MS_FIRST;
                    end else begin
                        // upper half to the next word
                        addr_d  = store_addr + 64'd4;
                        wdata_d = rs2_data_i[63:32];
                        step_d  = MS_IDLE;
                    end
                end
                default: step_d = step_q;
            endcase
        end
    end

    // enables are one-cycle pulses, in the bubble after issue
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            step_q             <= MS_IDLE;
            bus_read_enable_o  <= 1'b0;
            bus_write_enable_o <= 1'b0;
        end else begin
            step_q             <= step_d;
            bus_read_enable_o  <= rd_en_d;
            bus_write_enable_o <= wr_en_d;
        end
    end

    // address held until the next access
    always_ff @(posedge clk) begin
        if (rd_en_d || wr_en_d) begin
            bus_address_o    <= addr_d;
            bus_write_data_o <= wdata_d;
        end
        if (low_capture) begin
            low_word_q <= bus_read_data_i;
        end
    end

endmodule

// File: source/rv64_trap_csr.sv
`timescale 1ns/1ps

module rv64_trap_csr
    import rv64_pkg::*;
#(
    parameter xlen_t TRAP_BASE = '0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] interrupt_i,
    input  logic       mret_i,
    input  xlen_t      exec_pc_i,
    input  logic       busy_i,
    output logic       trap_take_o,
    output xlen_t      trap_pc_o,
    output logic       interrupt_ack_o
);

    xlen_t mstatus_q;
    xlen_t mepc_q;
    xlen_t mcause_q;

    // level request, only code 1 is external
    // held off while a bus access is underway
    assign trap_take_o = (interrupt_i == 4'd1) && mstatus_q[MSTATUS_MIE_BIT] && !busy_i;

    // vector on entry, saved pc on mret
    assign trap_pc_o = trap_take_o ? TRAP_BASE : mepc_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_q       <= MSTATUS_RESET;
            mepc_q          <= '0;
            mcause_q        <= '0;
            interrupt_ack_o <= 1'b0;
        end else begin
            // ack follows entry by one cycle
            interrupt_ack_o <= trap_take_o;
            if (trap_take_o) begin
                // resume point is the interrupted instruction
                mepc_q                      <= exec_pc_i;
                mcause_q                    <= MCAUSE_EXT_IRQ;
                mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
                mstatus_q[MSTATUS_MIE_BIT]  <= 1'b0;
            end else if (mret_i) begin
                mstatus_q[MSTATUS_MIE_BIT]  <= mstatus_q[MSTATUS_MPIE_BIT];
                mstatus_q[MSTATUS_MPIE_BIT] <= 1'b1;
            end
        end
    end

endmodule

// File: source/rv64_core.sv
`timescale 1ns/1ps

module rv64_core
    import rv64_pkg::*;
#(
    parameter xlen_t RAM_BASE  = '0,
    parameter xlen_t TRAP_BASE = '0
) (
    input  logic       clk,
    input  logic       reset,
    input  word_t      instruction_i,
    output xlen_t      pc_o,
    output xlen_t      bus_address_o,
    output word_t      bus_write_data_o,
    output logic       bus_write_enable_o,
    output logic       bus_read_enable_o,
    input  word_t      bus_read_data_i,
    input  logic [3:0] interrupt_i,
    output logic       interrupt_ack_o
);

    word_t       ir_q;
    xlen_t       pc_q;
    xlen_t       pc_d;
    logic        bubble_q;
    logic        bubble_d;
    logic        mem_busy_q;
    xlen_t       inst_pc;
    xlen_t       resume_pc;
    logic        exec;
    logic        mret;
    logic        mem_rewind;
    logic        store_tail;
    inst_class_e inst_class;
    reg_idx_t    rd, rs1, rs2;
    xlen_t       imm_i, imm_s, imm_u, imm_j, imm_b;
    logic [5:0]  shamt;
    xlen_t       rs1_data, rs2_data, rd_data;
    logic        rd_we;
    xlen_t       alu_result, alu_target;
    logic        alu_we, alu_redirect;
    logic        load_we;
    xlen_t       load_data;
    logic        mem_hold;
    logic        trap_take;
    xlen_t       trap_pc;

    assign pc_o = pc_q;

    // ir trails the fetch by one cycle, so pc is 4 ahead of it
    assign inst_pc   = pc_q - 64'd4;
    // in a bubble the ir word is dropped and pc is where to resume
    assign resume_pc = bubble_q ? pc_q : inst_pc;

    assign exec       = !bubble_q && !trap_take;
    assign mret       = exec && (inst_class == I_MRET);
    assign mem_rewind = exec && mem_hold;
    // last store step, bubble without rewind
    assign store_tail = exec && !mem_hold && (inst_class == I_SW || inst_class == I_SD);

    // load capture wins over the alu
    assign rd_we   = load_we || (exec && alu_we);
    assign rd_data = load_we ? load_data : alu_result;

    // next pc by priority
    always_comb begin
        pc_d     = pc_q + 64'd4;
        bubble_d = 1'b1;
        if (trap_take || mret) begin
            pc_d = trap_pc;
        end else if (mem_rewind) begin
            pc_d = inst_pc;
        end else if (store_tail) begin
            pc_d = pc_q;
        end else if (exec && alu_redirect) begin
            pc_d = alu_target;
        end else begin
            bubble_d = 1'b0;
        end
    end

    // reset ir is not a real fetch, so start in a bubble
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir_q       <= IR_RESET;
            pc_q       <= RAM_BASE;
            bubble_q   <= 1'b1;
            mem_busy_q <= 1'b0;
        end else begin
            ir_q     <= instruction_i;
            pc_q     <= pc_d;
            bubble_q <= bubble_d;
            // an access spans its bubble and the step after it
            if (mem_rewind) begin
                mem_busy_q <= 1'b1;
            end else if (exec) begin
                mem_busy_q <= 1'b0;
            end
        end
    end

    rv64_decoder u_decoder (
        .ir_i         (ir_q),
        .inst_class_o (inst_class),
        .rd_o         (rd),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .imm_i_o      (imm_i),
        .imm_s_o      (imm_s),
        .imm_u_o      (imm_u),
        .imm_j_o      (imm_j),
        .imm_b_o      (imm_b),
        .shamt_o      (shamt)
    );

    rv64_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rd),
        .rd_we_i    (rd_we),
        .rd_data_i  (rd_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv64_alu u_alu (
        .inst_class_i (inst_class),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .imm_i_i      (imm_i),
        .imm_u_i      (imm_u),
        .imm_j_i      (imm_j),
        .imm_b_i      (imm_b),
        .shamt_i      (shamt),
        .pc_i         (inst_pc),
        .result_o     (alu_result),
        .result_we_o  (alu_we),
        .redirect_o   (alu_redirect),
        .target_o     (alu_target)
    );

    rv64_mem_seq u_mem_seq (
        .clk                (clk),
        .reset              (reset),
        .inst_class_i       (inst_class),
        .exec_i             (exec),
        .rs1_data_i         (rs1_data),
        .rs2_data_i         (rs2_data),
        .imm_i_i            (imm_i),
        .imm_s_i            (imm_s),
        .bus_read_data_i    (bus_read_data_i),
        .bus_address_o      (bus_address_o),
        .bus_write_data_o   (bus_write_data_o),
        .bus_write_enable_o (bus_write_enable_o),
        .bus_read_enable_o  (bus_read_enable_o),
        .load_we_o          (load_we),
        .load_data_o        (load_data),
        .mem_hold_o         (mem_hold)
    );

    // ir garbage in a bubble must not hold off an interrupt
    rv64_trap_csr #(
        .TRAP_BASE (TRAP_BASE)
    ) u_trap_csr (
        .clk             (clk),
        .reset           (reset),
        .interrupt_i     (interrupt_i),
        .mret_i          (mret),
        .exec_pc_i       (resume_pc),
        .busy_i          ((mem_hold && !bubble_q) || mem_busy_q),
        .trap_take_o     (trap_take),
        .trap_pc_o       (trap_pc),
        .interrupt_ack_o (interrupt_ack_o)
    );

endmodule

// File: dv/rv64_core_tb.sv
`timescale 1ns/1ps

module rv64_core_tb;

    logic        clk;
    logic        reset;
    logic [31:0] instruction_i;
    logic [63:0] pc_o;
    logic [63:0] bus_address_o;
    logic [31:0] bus_write_data_o;
    logic        bus_write_enable_o;
    logic        bus_read_enable_o;
    logic [31:0] bus_read_data_i;
    logic [3:0]  interrupt_i;
    logic        interrupt_ack_o;

    // word-indexed memories on byte address bits 7:2 and 9:2
    logic [31:0]  imem [0:63];
    logic [31:0]  dmem [0:255];
    logic [31:0]  exp_addr [$];
    logic [31:0]  exp_data [$];
    reg   [255:0] cur_name;
    // wide enough for a whole comment line of the pattern file
    reg   [1023:0] line;
    int           fd;
    int           irq_flag;
    int           n_prog;
    int           n_tests;
    int           cycle_count;
    int           cycle_limit;
    int           write_count;
    int           ack_count;
    int           ack_high_count;
    int           test_errors;
    int           file_errors;
    int           pass_count;
    int           fail_count;
    logic [63:0]  spin_addr;
    logic [31:0]  lfsr_q;
    bit           have_test;

    rv64_core dut_i (
        .clk                (clk),
        .reset              (reset),
        .instruction_i      (instruction_i),
        .pc_o               (pc_o),
        .bus_address_o      (bus_address_o),
        .bus_write_data_o   (bus_write_data_o),
        .bus_write_enable_o (bus_write_enable_o),
        .bus_read_enable_o  (bus_read_enable_o),
        .bus_read_data_i    (bus_read_data_i),
        .interrupt_i        (interrupt_i),
        .interrupt_ack_o    (interrupt_ack_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // watchdog with its limit set once the tests are counted
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, test %0s stalled", cycle_count, cur_name);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_wait(output int w);
        logic [3:0] bits;
        bits = '0;
        for (int i = 0; i < 4; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            bits   = {bits[2:0], lfsr_q[0]};
        end
        w = int'(bits);
    endtask

    // one cycle with all inputs changed at the falling edge
    task automatic tick;
        @(negedge clk);
        instruction_i = imem[pc_o[7:2]];
        // read data stays put until the next read
        if (bus_read_enable_o) begin
            bus_read_data_i = dmem[bus_address_o[9:2]];
        end
        if (bus_write_enable_o) begin
            if (write_count >= exp_addr.size()) begin
                $display("test %0s: unexpected write of %h to %h", cur_name,
                         bus_write_data_o, bus_address_o);
                test_errors++;
            end else if (bus_address_o != {32'd0, exp_addr[write_count]} ||
                         bus_write_data_o != exp_data[write_count]) begin
                $display("mismatch test %0s write %0d: expected %h at %h, actual %h at %h",
                         cur_name, write_count, exp_data[write_count],
                         exp_addr[write_count], bus_write_data_o, bus_address_o[31:0]);
                test_errors++;
            end
            dmem[bus_address_o[9:2]] = bus_write_data_o;
            write_count++;
        end
        // request dropped on the acknowledge
        if (interrupt_ack_o) begin
            ack_count++;
            if (interrupt_i != 4'd0) begin
                ack_high_count++;
                interrupt_i = 4'd0;
            end
        end
    endtask

    task automatic count_tests;
        reg [255:0] tok;
        int         code;
        n_tests = 0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") code = $fgets(line, fd);
            else if (tok == "test") n_tests++;
        end
    endtask

    // loads memories and expected writes up to the next end keyword
    task automatic read_test(output bit got);
        reg [255:0]  tok;
        logic [31:0] a;
        logic [31:0] v;
        int          code;
        bit          done;
        got    = 0;
        done   = 0;
        n_prog = 0;
        for (int i = 0; i < 64; i++) imem[i] = '0;
        for (int i = 0; i < 256; i++) dmem[i] = '0;
        exp_addr.delete();
        exp_data.delete();
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1;
            end else if (tok == "#") begin
                code = $fgets(line, fd);
            end else if (tok == "test") begin
                code = $fscanf(fd, "%s %d", cur_name, irq_flag);
                got  = 1;
            end else if (tok == "prog") begin
                code         = $fscanf(fd, "%h", v);
                imem[n_prog] = v;
                n_prog++;
            end else if (tok == "data") begin
                code          = $fscanf(fd, "%h %h", a, v);
                dmem[a[9:2]] = v;
            end else if (tok == "write") begin
                code = $fscanf(fd, "%h %h", a, v);
                exp_addr.push_back(a);
                exp_data.push_back(v);
            end else if (tok == "end") begin
                done = 1;
            end else begin
                $display("unknown keyword %0s in pattern file", tok);
                file_errors++;
                done = 1;
            end
        end
    endtask

    task automatic run_test;
        int wait_cycles;
        test_errors    = 0;
        write_count    = 0;
        ack_count      = 0;
        ack_high_count = 0;
        // last program word is the spin loop
        spin_addr      = 64'(4 * (n_prog - 1));
        reset          = 1'b0;
        interrupt_i    = 4'd0;
        repeat (10) tick;
        if (pc_o != 64'd0 || bus_read_enable_o || bus_write_enable_o || interrupt_ack_o) begin
            $display("test %0s: outputs not at their reset values", cur_name);
            test_errors++;
        end
        reset = 1'b1;
        if (irq_flag != 0) begin
            // let the program reach its spin first
            draw_wait(wait_cycles);
            repeat (20 + wait_cycles) tick;
            interrupt_i = 4'd1;
        end
        while (write_count < exp_addr.size() || (irq_flag != 0 && ack_count == 0)) begin
            tick;
        end
        // quiet period to catch late or extra writes
        repeat (30) tick;
        if (pc_o != spin_addr && pc_o != spin_addr + 64'd4) begin
            $display("test %0s: pc %h did not settle at the spin loop %h", cur_name,
                     pc_o, spin_addr);
            test_errors++;
        end
        if (ack_count != (irq_flag != 0 ? 1 : 0)) begin
            $display("test %0s: interrupt acknowledge pulsed %0d times", cur_name, ack_count);
            test_errors++;
        end
        if (irq_flag != 0 && ack_high_count != 1) begin
            $display("test %0s: acknowledge came while the interrupt was low", cur_name);
            test_errors++;
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0s: passed, %0d writes", cur_name, write_count);
        end else begin
            fail_count++;
            $display("test %0s: failed with %0d errors", cur_name, test_errors);
        end
    endtask

    initial begin
        reset           = 1'b0;
        instruction_i   = '0;
        bus_read_data_i = '0;
        interrupt_i     = 4'd0;
        lfsr_q          = 32'h108cad12;
        cycle_count     = 0;
        cycle_limit     = 0;
        file_errors     = 0;
        pass_count      = 0;
        fail_count      = 0;
        cur_name        = "setup";
        fd = $fopen("dv/rv64_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file dv/rv64_patterns.txt");
            file_errors++;
        end else begin
            count_tests();
            $fclose(fd);
            cycle_limit = 200 * n_tests;
            fd = $fopen("dv/rv64_patterns.txt", "r");
            read_test(have_test);
            while (have_test) begin
                run_test();
                read_test(have_test);
            end
            $fclose(fd);
        end
        $display("%0d tests: %0d passed, %0d failed, %0d file errors",
                 pass_count + fail_count, pass_count, fail_count, file_errors);
        if (fail_count == 0 && file_errors == 0 && pass_count > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: dv/rv64_patterns.txt
# test <name> <irq 0|1>, prog <instruction hex>, data <address hex> <word hex>
# write <address hex> <word hex> in expected order, end closes a test
test arith 0
prog 123450B7 prog 67808093 prog FFD00113 prog 00409193 prog 0080D213
prog 002082B3 prog 40208333 prog 001123B3 prog 0020A433
prog 10102023 prog 10202223 prog 10302423 prog 10402623
prog 10502823 prog 10602A23 prog 10702C23 prog 10802E23
prog 00000063
write 100 12345678
write 104 FFFFFFFD
write 108 23456780
write 10C 00123456
write 110 12345675
write 114 1234567B
write 118 00000001
write 11C 00000000
end
test loads 0
prog 20002083 prog 20006103 prog 20003183
prog 30103023 prog 30203423 prog 30303823
prog 00000063
data 200 80000001
data 204 7ABCDEF0
write 300 80000001
write 304 FFFFFFFF
write 308 80000001
write 30C 00000000
write 310 80000001
write 314 7ABCDEF0
end
test control 0
prog 00500093 prog 0080016F prog 10102023 prog 10202023
prog 01D00193 prog 00818267 prog 10102223 prog 10102223
prog 10102223 prog 10402223 prog 00008463 prog 10102423
prog 00000463 prog 10102623 prog 10302623 prog 00000063
write 100 00000008
write 104 00000018
write 108 00000005
write 10C 0000001D
end
test auipc 0
prog 00000013 prog 00000013 prog 12345097 prog 80000117
prog 10102023 prog 10203423 prog 00000063
write 100 12345008
write 108 8000000C
write 10C FFFFFFFF
end
test interrupt 1
prog 00028663 prog 10602023 prog 30200073
prog 00100293 prog 0A500313 prog 00000063
write 100 000000A5
end

// File: rv64_core.f
common/rv64_pkg.sv
source/rv64_decoder.sv
source/rv64_regfile.sv
source/rv64_alu.sv
mem_unit/rv64_mem_seq.sv
source/rv64_trap_csr.sv
source/rv64_core.sv
dv/rv64_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rv64_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f rv64_core.f --top-module rv64_core_tb \
    -o rv64_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/rv64_sim > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $SIM_LOG"
    exit 1
fi

cat "$SIM_LOG"

if grep -q "CHECKS FAILED" "$SIM_LOG"; then
    echo "result: fail"
    exit 1
fi

echo "result: pass"
exit 0
